//--- include/adxl355_log_consts.svh
/*
  default sizes for the adxl355 logger timing core
  rates are in Hz, tolerance and widths in clk cycles
  sync stages must be 2 or more
*/
`ifndef ADXL355_LOG_CONSTS_SVH
`define ADXL355_LOG_CONSTS_SVH

// system clock, fed directly without the vendor PLL
`define ADXL355_CLK_HZ 40000000

// DRDY/SYNC output rate = sensor sample rate
`define ADXL355_SYNC_HZ 1000

// allowed deviation of one PPS period from nominal
// 20000 cycles = 500 us at 40 MHz
`define ADXL355_PPS_TOL_CYC 20000

// good periods in a row before pps_valid
`define ADXL355_PPS_GOOD_N 2

// drdy high time in cycles
`define ADXL355_SYNC_WIDTH 4

// metastability flops on the PPS input
`define ADXL355_PPS_SYNC_STAGES 2

`endif

//--- list.f
+incdir+include
src/adxl355_log_pkg.sv
src/pps_gen.sv
src/pps_monitor.sv
src/sync_gen.sv
src/adxl355_log_top.sv
testbench/adxl355_log_checker.sv
testbench/tb_adxl355_log.sv

//--- run_sim.sh
#!/bin/sh
# build tb_adxl355_log with Verilator, run it, judge the result from sim.log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module tb_adxl355_log -o sim_tb
if ! ./obj_dir/sim_tb > sim.log 2>&1
then
  cat sim.log
  echo "simulator exited with an error"
  exit 1
fi
cat sim.log
if grep -q "Simulation failed" sim.log
then
  exit 1
fi
grep -q "Simulation passed" sim.log

//--- src/adxl355_log_pkg.sv
/*
  types shared by the adxl355 logger timing core
  cycle counts are one 32 bit word, enough for 1 s at 40 MHz plus tolerance
*/
package adxl355_log_pkg;

  // clk cycles, one PPS period plus margin
  typedef logic [31:0] cycle_cnt_t;

  // sync pulses per second
  typedef logic [15:0] sync_rate_t;

  // pps monitor FSM
  typedef enum logic [1:0] {
    pps_wait_first = 2'd0, // no edge seen yet
    pps_measuring  = 2'd1, // counting good periods
    pps_locked     = 2'd2  // reference valid
  } pps_state_e;

endpackage

//--- src/adxl355_log_top.sv
/*
  timing core of the adxl355 logger, clk supplied directly
  pps_sel 1 = internal reference, 0 = external pps_ext (asynchronous)
  SPI pins pass straight through with no delay
*/
`timescale 1ns/1ps
`include "adxl355_log_consts.svh"

module adxl355_log_top #(
  parameter adxl355_log_pkg::cycle_cnt_t clk_hz      = `ADXL355_CLK_HZ,
  parameter adxl355_log_pkg::sync_rate_t sync_hz     = `ADXL355_SYNC_HZ,
  parameter adxl355_log_pkg::cycle_cnt_t pps_tol_cyc = `ADXL355_PPS_TOL_CYC
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       pps_ext,
  input  logic       pps_sel,
  input  logic       esp_csn,
  input  logic       esp_mosi,
  input  logic       esp_sclk,
  output logic       esp_miso,
  output logic       adxl_csn,
  output logic       adxl_mosi,
  output logic       adxl_sclk,
  input  logic       adxl_miso,
  input  logic       adxl_int1,
  input  logic       adxl_int2,
  output logic       drdy,
  output logic       pps_valid,
  output logic [7:0] led
);

  logic                        pps_int;    // bench reference
  logic                        pps_ref;    // selected source, registered
  logic                        pps_accept; // qualified edge pulse
  adxl355_log_pkg::cycle_cnt_t period_cyc; // last accepted period

  // source mux, one flop before the monitor
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pps_ref <= 1'b0;
    end
    else
    begin
      pps_ref <= pps_sel ? pps_int : pps_ext;
    end
  end

  pps_gen #(
    .clk_hz(clk_hz)
  ) pps_gen0 (
    .clk   (clk),
    .arst_n(arst_n),
    .pps   (pps_int)
  );

  pps_monitor #(
    .clk_hz     (clk_hz),
    .pps_tol_cyc(pps_tol_cyc)
  ) pps_monitor0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .pps       (pps_ref),
    .pps_accept(pps_accept),
    .period_cyc(period_cyc),
    .pps_valid (pps_valid)
  );

  sync_gen #(
    .sync_hz(sync_hz)
  ) sync_gen0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .pps_accept(pps_accept),
    .period_cyc(period_cyc),
    .drdy      (drdy)       // to ADXL355 DRDY/SYNC pin
  );

  // host SPI straight to the sensor
  assign adxl_csn  = esp_csn;
  assign adxl_mosi = esp_mosi;
  assign adxl_sclk = esp_sclk;
  assign esp_miso  = adxl_miso;

  // status LEDs, 7 down to 0
  assign led = {drdy, adxl_int2, adxl_int1, 3'b000, pps_valid, pps_ref};

endmodule

//--- src/pps_gen.sv
/*
  internal 1 Hz reference, stands in for a GNSS receiver on the bench
  high for the first clk_hz/10 cycles of each clk_hz cycle period
  first rise one cycle after reset release
*/
`timescale 1ns/1ps
`include "adxl355_log_consts.svh"

module pps_gen #(
  parameter adxl355_log_pkg::cycle_cnt_t clk_hz = `ADXL355_CLK_HZ
) (
  input  logic clk,
  input  logic arst_n,
  output logic pps
);

  localparam adxl355_log_pkg::cycle_cnt_t cnt_max = clk_hz - 1; // last count of period
  localparam adxl355_log_pkg::cycle_cnt_t pps_w   = clk_hz / 10; // 100 ms duty

  adxl355_log_pkg::cycle_cnt_t cnt_q; // position within period

  // free running period counter
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cnt_q <= '0;
    end
    else if (cnt_q == cnt_max)
    begin
      cnt_q <= '0; // wrap each second
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // set at period start, clear one tenth later
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pps <= 1'b0;
    end
    else if (cnt_q == '0)
    begin
      pps <= 1'b1; // rising edge = second boundary
    end
    else if (cnt_q == pps_w)
    begin
      pps <= 1'b0;
    end
  end

endmodule

//--- src/pps_monitor.sv
/*
  PPS qualifier for an asynchronous pps input, rising edges only
  edge seen 3 cycles after pps changes (2 sync flops + edge flop)
  accept window is clk_hz +- pps_tol_cyc inclusive and tol must be below clk_hz
  first edge after reset or timeout only starts a measurement
*/
`timescale 1ns/1ps
`include "adxl355_log_consts.svh"

module pps_monitor #(
  parameter adxl355_log_pkg::cycle_cnt_t clk_hz      = `ADXL355_CLK_HZ,
  parameter adxl355_log_pkg::cycle_cnt_t pps_tol_cyc = `ADXL355_PPS_TOL_CYC
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        pps,
  output logic                        pps_accept,
  output adxl355_log_pkg::cycle_cnt_t period_cyc,
  output logic                        pps_valid
);

  localparam int sync_n = `ADXL355_PPS_SYNC_STAGES;
  localparam int good_n = `ADXL355_PPS_GOOD_N;
  localparam int good_w = $clog2(good_n + 1);
  localparam adxl355_log_pkg::cycle_cnt_t per_min = clk_hz - pps_tol_cyc;
  localparam adxl355_log_pkg::cycle_cnt_t per_max = clk_hz + pps_tol_cyc;

  logic [sync_n-1:0]           sync_q;   // metastability chain
  logic                        sync_d;   // previous synced level
  logic                        edge_q;   // one cycle per rising edge
  adxl355_log_pkg::cycle_cnt_t per_cnt;  // cycles since last edge cycle
  logic [good_w-1:0]           good_cnt; // good periods in a row, saturates
  adxl355_log_pkg::pps_state_e state_q;
  logic                        in_window;
  logic                        measuring;
  logic                        timeout;

  // synchronizer and registered edge detect
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sync_q <= '0;
      sync_d <= 1'b0;
      edge_q <= 1'b0;
    end
    else
    begin
      sync_q <= {sync_q[sync_n-2:0], pps};
      sync_d <= sync_q[sync_n-1];
      edge_q <= sync_q[sync_n-1] & ~sync_d; // rising only
    end
  end

  assign in_window  = (per_cnt >= per_min) && (per_cnt <= per_max);
  assign measuring  = (state_q != adxl355_log_pkg::pps_wait_first);
  assign timeout    = measuring && !edge_q && (per_cnt >= per_max); // edge overdue
  assign pps_accept = edge_q && measuring && in_window; // same cycle as edge
  assign pps_valid  = (state_q == adxl355_log_pkg::pps_locked);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q    <= adxl355_log_pkg::pps_wait_first;
      per_cnt    <= '0;
      good_cnt   <= '0;
      period_cyc <= clk_hz; // nominal until first accept
    end
    else if (edge_q)
    begin
      per_cnt <= adxl355_log_pkg::cycle_cnt_t'(1); // edge cycle is count 0
      if (pps_accept)
      begin
        period_cyc <= per_cnt;
        if (good_cnt != good_w'(good_n))
        begin
          good_cnt <= good_cnt + 1'b1;
        end
        if (good_cnt >= good_w'(good_n - 1))
        begin
          state_q <= adxl355_log_pkg::pps_locked; // this edge completes the run
        end
        else
        begin
          state_q <= adxl355_log_pkg::pps_measuring;
        end
      end
      else
      begin
        // first edge, or period out of window
        good_cnt <= '0;
        state_q  <= adxl355_log_pkg::pps_measuring;
      end
    end
    else if (timeout)
    begin
      state_q  <= adxl355_log_pkg::pps_wait_first; // reference lost
      per_cnt  <= '0;
      good_cnt <= '0;
    end
    else if (measuring)
    begin
      per_cnt <= per_cnt + 1'b1;
    end
  end

  // accept needs a previous edge to measure from
  a_no_accept_first: assert property (@(posedge clk) disable iff (!arst_n)
    pps_accept |-> (state_q != adxl355_log_pkg::pps_wait_first))
    else $error("pps_accept in pps_wait_first");

  // timeout keeps the counter inside the window
  a_cnt_bound: assert property (@(posedge clk) disable iff (!arst_n)
    per_cnt <= per_max)
    else $error("period counter above nominal + tolerance");

endmodule

//--- src/sync_gen.sv
/*
  DRDY/SYNC generator, fractional phase accumulator
  sync_hz pulses per period_cyc with no cumulative error
  sync_hz must be below period_cyc, drdy rises one cycle after a start
*/
`timescale 1ns/1ps
`include "adxl355_log_consts.svh"

module sync_gen #(
  parameter adxl355_log_pkg::sync_rate_t sync_hz = `ADXL355_SYNC_HZ
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        pps_accept,
  input  adxl355_log_pkg::cycle_cnt_t period_cyc,
  output logic                        drdy
);

  localparam int acc_w = $bits(adxl355_log_pkg::cycle_cnt_t);
  localparam int width = `ADXL355_SYNC_WIDTH;
  localparam int wid_w = $clog2(width + 1);

  adxl355_log_pkg::cycle_cnt_t acc_q;   // phase, always below period_cyc
  logic [acc_w:0]              acc_sum; // one spare bit for the add
  logic                        wrap;    // phase passed a slot boundary
  logic                        start;   // begin a drdy pulse
  logic [wid_w-1:0]            wid_cnt; // remaining high cycles after the first

  assign acc_sum = {1'b0, acc_q} + (acc_w + 1)'(sync_hz);
  assign wrap    = (acc_sum >= {1'b0, period_cyc});
  assign start   = pps_accept | wrap; // accepted edge realigns phase

  // phase accumulator
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      acc_q <= '0;
    end
    else if (pps_accept)
    begin
      acc_q <= '0; // restart phase on disciplined edge
    end
    else if (wrap)
    begin
      acc_q <= acc_w'(acc_sum - {1'b0, period_cyc}); // keep remainder
    end
    else
    begin
      acc_q <= acc_w'(acc_sum);
    end
  end

  // pulse shaper, restart extends the width
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      drdy    <= 1'b0;
      wid_cnt <= '0;
    end
    else if (start)
    begin
      drdy    <= 1'b1;
      wid_cnt <= wid_w'(width - 1);
    end
    else if (wid_cnt != '0)
    begin
      wid_cnt <= wid_cnt - 1'b1; // drdy holds
    end
    else
    begin
      drdy <= 1'b0;
    end
  end

  // phase never reaches a full period, even across period reloads
  a_acc_bound: assert property (@(posedge clk) disable iff (!arst_n)
    acc_q < period_cyc)
    else $error("sync accumulator not below period_cyc");

endmodule

//--- testbench/adxl355_log_checker.sv
/*
  reference model of the pps path, monitor, sync generator and pin map
  samples on the falling clock edge and steps the model once per cycle
  test boundaries come from test_id and a one cycle test_done
*/
`timescale 1ns/1ps
`include "adxl355_log_consts.svh"

module adxl355_log_checker #(
  parameter int clk_hz      = 2000,
  parameter int sync_hz     = 10,
  parameter int pps_tol_cyc = 40
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       pps_ext,
  input  logic       pps_sel,
  input  logic       esp_csn,
  input  logic       esp_mosi,
  input  logic       esp_sclk,
  input  logic       esp_miso,
  input  logic       adxl_csn,
  input  logic       adxl_mosi,
  input  logic       adxl_sclk,
  input  logic       adxl_miso,
  input  logic       adxl_int1,
  input  logic       adxl_int2,
  input  logic       drdy,
  input  logic       pps_valid,
  input  logic [7:0] led,
  input  logic [3:0] test_id,
  input  logic       test_done,
  output int         err_total,
  output int         bad_tests,
  output int         test_count
);

  localparam int good_n = `ADXL355_PPS_GOOD_N;
  localparam int width  = `ADXL355_SYNC_WIDTH;
  localparam int per_lo = clk_hz - pps_tol_cyc;
  localparam int per_hi = clk_hz + pps_tol_cyc;

  int         m_cyc;      // cycles since reset release
  logic [4:0] m_hist;     // registered reference, bit 0 = this cycle
  int         m_lock;     // 0 no edge yet, 1 measuring, 2 locked
  int         m_gap;      // cycles since last edge cycle
  int         m_good;
  int         m_period;   // last accepted period
  int         m_acc;      // sync phase
  int         m_hi;       // drdy high cycles left, this one included
  int         test_errs;
  int         drdy_rises;
  logic       drdy_prev;

  // internal reference high for the first tenth of every period
  function automatic logic int_level(input int c);
    return ((c % clk_hz) >= 1) && ((c % clk_hz) <= clk_hz / 10);
  endfunction

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1:    return "reset_state";
      4'd2:    return "lock_and_phase";
      4'd3:    return "out_of_tolerance";
      4'd4:    return "lost_pps";
      4'd5:    return "internal_source";
      default: return "pass_through";
    endcase
  endfunction

  task automatic expect_bit(input string name, input logic want, input logic got);
    if (got !== want)
    begin
      $display("MISMATCH at %0t ns %s expected %0b got %0b", $time, name, want, got);
      test_errs++;
      err_total++;
    end
  endtask

  task automatic expect_byte(input string name, input logic [7:0] want, input logic [7:0] got);
    if (got !== want)
    begin
      $display("MISMATCH at %0t ns %s expected %02h got %02h", $time, name, want, got);
      test_errs++;
      err_total++;
    end
  endtask

  task automatic clear_model();
    m_cyc      = 0;
    m_hist     = '0;
    m_lock     = 0;
    m_gap      = 0;
    m_good     = 0;
    m_period   = clk_hz; // nominal before any accept
    m_acc      = 0;
    m_hi       = 0;
    test_errs  = 0;
    drdy_rises = 0;
    drdy_prev  = 1'b0;
    err_total  = 0;
    bad_tests  = 0;
    test_count = 0;
  endtask

  task automatic compare_pins();
    logic exp_drdy;
    logic exp_valid;
    exp_drdy  = (m_hi != 0);
    exp_valid = (m_lock == 2);
    expect_bit("drdy", exp_drdy, drdy);
    expect_bit("pps_valid", exp_valid, pps_valid);
    expect_bit("adxl_csn", esp_csn, adxl_csn); // zero delay pass-through
    expect_bit("adxl_mosi", esp_mosi, adxl_mosi);
    expect_bit("adxl_sclk", esp_sclk, adxl_sclk);
    expect_bit("esp_miso", adxl_miso, esp_miso);
    expect_byte("led", {exp_drdy, adxl_int2, adxl_int1, 3'b000, exp_valid, m_hist[0]}, led);
    if (drdy && !drdy_prev)
    begin
      drdy_rises++;
    end
    drdy_prev = drdy;
  endtask

  task automatic finish_test();
    logic want_valid;
    want_valid = !(test_id == 4'd1 || test_id == 4'd4); // no reference in 1 and 4
    if (pps_valid !== want_valid)
    begin
      $display("test %0d ends with pps_valid %0b instead of %0b", test_id, pps_valid, want_valid);
      test_errs++;
      err_total++;
    end
    if (drdy_rises == 0)
    begin
      $display("test %0d saw no drdy pulse at all", test_id);
      test_errs++;
      err_total++;
    end
    test_count++;
    if (test_errs != 0)
    begin
      bad_tests++;
    end
    $display("test %0d %s %s, %0d errors, %0d drdy pulses", test_id, test_name(test_id),
             (test_errs == 0) ? "ok" : "FAIL", test_errs, drdy_rises);
    test_errs  = 0;
    drdy_rises = 0;
  endtask

  // advance from this cycle to the next one
  task automatic step_model();
    logic edge_now;
    logic accept;
    logic start;
    int   sum;
    edge_now = m_hist[3] & ~m_hist[4]; // 3 cycles behind pps_ref
    accept   = edge_now && (m_lock != 0) && (m_gap >= per_lo) && (m_gap <= per_hi);
    sum      = m_acc + sync_hz;
    start    = 1'b1;
    if (accept)
    begin
      m_acc = 0; // phase restart on a good edge
    end
    else if (sum >= m_period)
    begin
      m_acc = sum - m_period;
    end
    else
    begin
      m_acc = sum;
      start = 1'b0;
    end
    m_hi = start ? width : ((m_hi > 0) ? m_hi - 1 : 0);
    if (edge_now)
    begin
      if (accept)
      begin
        m_period = m_gap;
        m_good   = (m_good < good_n) ? m_good + 1 : good_n;
        m_lock   = (m_good >= good_n) ? 2 : 1;
      end
      else
      begin
        m_good = 0; // first edge or bad period
        m_lock = 1;
      end
      m_gap = 1;
    end
    else if (m_lock != 0 && m_gap >= per_hi)
    begin
      m_lock = 0; // edge overdue, reference lost
      m_gap  = 0;
      m_good = 0;
    end
    else if (m_lock != 0)
    begin
      m_gap++;
    end
    m_hist = {m_hist[3:0], pps_sel ? int_level(m_cyc) : pps_ext};
    m_cyc++;
  endtask

  always @(negedge clk)
  begin
    if (!arst_n)
    begin
      clear_model();
    end
    else
    begin
      compare_pins();
      if (test_done)
      begin
        finish_test();
      end
      step_model();
    end
  end

endmodule

//--- testbench/tb_adxl355_log.sv
/*
  testbench for the adxl355 logger timing core at a 2 kHz clock
  one pps period = 2000 cycles, tolerance 40 cycles, sync rate 10
  pps jitter, SPI pins and interrupts come from a 16 bit LFSR seeded with 41
*/
`timescale 1ns/1ps

module tb_adxl355_log;

  localparam int clk_hz       = 2000;
  localparam int sync_hz      = 10;
  localparam int pps_tol_cyc  = 40;
  localparam int test_periods = 18; // pps periods over all six tests
  localparam int cycle_limit  = test_periods * 2100;

  logic        clk;
  logic        arst_n;
  logic        pps_ext;
  logic        pps_sel;
  logic        esp_csn;
  logic        esp_mosi;
  logic        esp_sclk;
  logic        esp_miso;
  logic        adxl_csn;
  logic        adxl_mosi;
  logic        adxl_sclk;
  logic        adxl_miso;
  logic        adxl_int1;
  logic        adxl_int2;
  logic        drdy;
  logic        pps_valid;
  logic [7:0]  led;
  logic [3:0]  test_id;        // test in progress
  logic        test_done;      // one cycle at the end of a test
  int          err_total;
  int          bad_tests;
  int          test_count;
  int          cyc_cnt;
  logic [15:0] lfsr_q = 16'd41;

  adxl355_log_top #(
    .clk_hz     (32'(clk_hz)),
    .sync_hz    (16'(sync_hz)),
    .pps_tol_cyc(32'(pps_tol_cyc))
  ) dut0 (.*);

  adxl355_log_checker #(
    .clk_hz     (clk_hz),
    .sync_hz    (sync_hz),
    .pps_tol_cyc(pps_tol_cyc)
  ) chk0 (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 125 MHz bench clock, stands for clk_hz
  end

  // fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic rand_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      v = (v << 1) | {31'd0, rand_bit()};
    end
    return v;
  endfunction

  function automatic int good_len();
    return clk_hz + take_bits(6) % 61 - 30; // within +-30
  endfunction

  function automatic int bad_len();
    int mag;
    mag = 61 + take_bits(5) % 30; // 61 to 90 cycles off
    return rand_bit() ? clk_hz + mag : clk_hz - mag;
  endfunction

  // one clock, fresh random levels on the pass-through pins
  task automatic tick();
    @(posedge clk);
    esp_csn   <= rand_bit();
    esp_mosi  <= rand_bit();
    esp_sclk  <= rand_bit();
    adxl_miso <= rand_bit();
    adxl_int1 <= rand_bit();
    adxl_int2 <= rand_bit();
  endtask

  task automatic run_cycles(input int n);
    repeat (n) tick();
  endtask

  // external pps, rise now, high for a tenth, next rise after len cycles
  task automatic pps_period(input int len);
    pps_ext <= 1'b1;
    run_cycles(clk_hz / 10);
    pps_ext <= 1'b0;
    run_cycles(len - clk_hz / 10);
  endtask

  task automatic end_test(input logic [3:0] next_id);
    test_done <= 1'b1;
    tick();
    test_done <= 1'b0;
    test_id   <= next_id;
  endtask

  initial
  begin
    arst_n    = 1'b0;
    pps_ext   = 1'b0;
    pps_sel   = 1'b0;
    esp_csn   = 1'b1;
    esp_mosi  = 1'b0;
    esp_sclk  = 1'b0;
    adxl_miso = 1'b0;
    adxl_int1 = 1'b0;
    adxl_int2 = 1'b0;
    test_id   = 4'd1;
    test_done = 1'b0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    run_cycles(clk_hz);                // no reference yet, nominal drdy
    end_test(4'd2);
    repeat (5) pps_period(good_len()); // jittered lock
    end_test(4'd3);
    pps_period(bad_len());
    repeat (3) pps_period(good_len()); // relock after the bad one
    end_test(4'd4);
    run_cycles(2 * clk_hz);            // pps_ext stays low
    end_test(4'd5);
    pps_sel <= 1'b1;                   // internal source from here on
    run_cycles(5 * clk_hz);
    end_test(4'd6);
    run_cycles(clk_hz);
    end_test(4'd0);
    $display("summary %0d tests, %0d failing, %0d errors", test_count, bad_tests, err_total);
    if (err_total == 0 && bad_tests == 0 && test_count == 6)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

  // run limit from the total pps periods
  always @(posedge clk)
  begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt == cycle_limit)
    begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule
